// File: src.f
+incdir+hw
hw/div_types_pkg.sv
hw/div_ctrl_pkg.sv
hw/div_ctrl_fsm.sv
hw/div_bit_counter.sv
hw/div_adder.sv
hw/div_regs.sv
hw/div_unit.sv
verification/div_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f src.f --top-module div_unit_tb \
  -Mdir "$OBJ" -o div_unit_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/div_unit_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi

echo "Simulation PASSED"
exit 0

// File: verification/div_unit_tb.sv
/*
 * Testbench for the iterative divider
 * Directed and random DIV and REM operations checked by concurrent assertions
 */

`default_nettype none

module div_unit_tb import div_types_pkg::*, div_ctrl_pkg::*; ();

  localparam int     CLK_PERIOD    = 8;
  localparam int     LAT_DIV       = 36;
  localparam int     LAT_ZERO      = 1;
  localparam int     OPS_TOTAL     = 79;
  localparam longint WATCHDOG_TIME = longint'((OPS_TOTAL * 60 + 100) * CLK_PERIOD);

  logic      clk_i;
  logic      rst_ni;
  logic      en_i;
  div_op_e   op_i;
  div_mode_t mode_i;
  div_word_t op_a_i;
  div_word_t op_b_i;
  logic      ready_i;
  div_word_t result_o;
  logic      valid_o;

  div_word_t exp_result;
  int        exp_latency;
  int        start_cycle;
  logic      op_active;
  int        cycle_cnt = 0;
  int        err_cnt = 0;
  int        op_cnt = 0;

  div_unit i_div_unit (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .en_i     (en_i),
    .op_i     (op_i),
    .mode_i   (mode_i),
    .op_a_i   (op_a_i),
    .op_b_i   (op_b_i),
    .ready_i  (ready_i),
    .result_o (result_o),
    .valid_o  (valid_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  result_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (op_active && valid_o && ready_i) |-> (result_o == exp_result))
  else begin
    err_cnt++;
    $display("error: %0t result_o got %h expected %h", $time, $sampled(result_o),
             $sampled(exp_result));
  end

  // Cycles from the first enabled idle cycle to the rise of valid_o
  latency_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (op_active && $rose(valid_o)) |-> (cycle_cnt - start_cycle == exp_latency))
  else begin
    err_cnt++;
    $display("error: %0t valid_o latency got %0d expected %0d", $time,
             $sampled(cycle_cnt) - $sampled(start_cycle), $sampled(exp_latency));
  end

  hold_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_o && !ready_i) |=> (valid_o && $stable(result_o)))
  else begin
    err_cnt++;
    $display("at %0t valid_o dropped or result_o changed while ready_i was low", $time);
  end

  accept_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_o && ready_i) |=> !valid_o)
  else begin
    err_cnt++;
    $display("at %0t valid_o stayed high in the cycle after the result was taken", $time);
  end

  reset_check: assert property (@(posedge clk_i)
    (!rst_ni || $rose(rst_ni)) |-> !valid_o)
  else begin
    err_cnt++;
    $display("at %0t valid_o was high during or right after reset", $time);
  end

  // Truncating division, computed wide so no case overflows
  function automatic div_word_t expected_result(div_op_e op, div_mode_t mode,
                                                div_word_t a, div_word_t b);
    longint sa;
    longint sb;
    longint res;
    if (b == '0) begin
      return (op == DIV_OP_DIV) ? '1 : a;
    end
    sa  = mode[0] ? longint'(signed'(a)) : longint'(a);
    sb  = mode[1] ? longint'(signed'(b)) : longint'(b);
    res = (op == DIV_OP_DIV) ? sa / sb : sa % sb;
    return div_word_t'(res);
  endfunction

  task automatic run_op(input div_op_e op, input div_mode_t mode, input div_word_t a,
                        input div_word_t b, input int pause_at, input int pause_len,
                        input int hold);
    int waited;
    @(posedge clk_i);
    #1;
    op_i        = op;
    mode_i      = mode;
    op_a_i      = a;
    op_b_i      = b;
    exp_result  = expected_result(op, mode, a, b);
    exp_latency = (b == '0) ? LAT_ZERO : LAT_DIV + pause_len;
    start_cycle = cycle_cnt;
    op_active   = 1'b1;
    en_i        = 1'b1;
    if (pause_len > 0) begin
      repeat (pause_at) @(posedge clk_i);
      #1;
      en_i = 1'b0;
      repeat (pause_len) @(posedge clk_i);
      #1;
      en_i = 1'b1;
    end
    waited = 0;
    while (!valid_o && waited < 2 * LAT_DIV + pause_len) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (!valid_o) begin
      err_cnt++;
      $display("valid_o never rose for operands %h and %h", a, b);
    end
    repeat (hold) begin
      @(posedge clk_i);
      #1;
    end
    ready_i = 1'b1;
    @(posedge clk_i);
    #1;
    ready_i   = 1'b0;
    en_i      = 1'b0;
    op_active = 1'b0;
    op_cnt++;
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %s finished with %0d errors", name, err_cnt - errs_before);
  endtask

  task automatic random_unsigned();
    int        errs;
    div_word_t a;
    div_word_t b;
    errs = err_cnt;
    for (int i = 0; i < 20; i++) begin
      a = $urandom;
      // Short divisors as well as full-width ones that often exceed A
      b = (i % 2 == 0) ? div_word_t'($urandom) : div_word_t'($urandom >> ($urandom % 32));
      if (b == '0) begin
        b = 1;
      end
      run_op((i % 4 < 2) ? DIV_OP_DIV : DIV_OP_REM, 2'b00, a, b, 0, 0, 0);
    end
    report_test("unsigned", errs);
  endtask

  task automatic signed_modes();
    int        errs;
    div_word_t a;
    div_word_t b;
    errs = err_cnt;
    for (int m = 0; m < 4; m++) begin
      for (int s = 0; s < 4; s++) begin
        for (int k = 0; k < 2; k++) begin
          a     = $urandom;
          b     = $urandom >> ($urandom % 24);
          a[31] = s[0];
          b[31] = s[1];
          if (b == '0) begin
            b = 3;
          end
          run_op((k == 1) ? DIV_OP_REM : DIV_OP_DIV, div_mode_t'(m), a, b, 0, 0, 0);
        end
      end
    end
    run_op(DIV_OP_DIV, 2'b11, 32'h8000_0000, 32'hffff_ffff, 0, 0, 0);
    run_op(DIV_OP_REM, 2'b11, 32'h8000_0000, 32'hffff_ffff, 0, 0, 0);
    report_test("signed", errs);
  endtask

  task automatic divide_by_zero();
    int errs;
    errs = err_cnt;
    for (int m = 0; m < 4; m++) begin
      run_op(DIV_OP_DIV, div_mode_t'(m), $urandom, '0, 0, 0, 0);
      run_op(DIV_OP_REM, div_mode_t'(m), $urandom, '0, 0, 0, 0);
    end
    report_test("div_zero", errs);
  endtask

  task automatic fixed_latency();
    int errs;
    errs = err_cnt;
    run_op(DIV_OP_DIV, 2'b00, 32'h0000_0000, 32'h0000_0001, 0, 0, 0);
    run_op(DIV_OP_REM, 2'b11, 32'hffff_ffff, 32'hffff_ffff, 0, 0, 0);
    run_op(DIV_OP_REM, 2'b00, 32'h0000_0005, 32'h0000_0007, 0, 0, 0);
    run_op(DIV_OP_DIV, 2'b00, 32'h0000_0001, 32'hffff_ffff, 0, 0, 0);
    report_test("latency", errs);
  endtask

  task automatic held_result();
    int errs;
    errs = err_cnt;
    for (int i = 0; i < 6; i++) begin
      run_op((i % 2 == 0) ? DIV_OP_DIV : DIV_OP_REM, div_mode_t'(i % 4), $urandom,
             $urandom | 32'h1, 0, 0, 1 + int'($urandom % 10));
    end
    report_test("backpressure", errs);
  endtask

  task automatic enable_pause();
    int errs;
    errs = err_cnt;
    for (int i = 0; i < 6; i++) begin
      run_op((i % 2 == 0) ? DIV_OP_REM : DIV_OP_DIV, div_mode_t'(3 - i % 4), $urandom,
             $urandom >> 4 | 32'h1, 2 + int'($urandom % 25), 1 + int'($urandom % 6), 0);
    end
    report_test("pause", errs);
  endtask

  // Reset arrives while a result is waiting, so valid_o must drop
  task automatic reset_with_valid();
    int errs;
    int waited;
    errs = err_cnt;
    @(posedge clk_i);
    #1;
    op_i   = DIV_OP_DIV;
    mode_i = 2'b00;
    op_a_i = $urandom;
    op_b_i = '0;
    en_i   = 1'b1;
    waited = 0;
    while (!valid_o && waited < 2 * LAT_DIV) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (!valid_o) begin
      err_cnt++;
      $display("valid_o never rose before reset was applied");
    end
    rst_ni = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    en_i   = 1'b0;
    // First cycle out of reset is checked as well
    repeat (2) @(posedge clk_i);
    #1;
    op_cnt++;
    report_test("reset", errs);
  endtask

  initial begin
    void'($urandom(32'h6d4));
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    en_i       = 1'b0;
    ready_i    = 1'b0;
    op_i       = DIV_OP_DIV;
    mode_i     = '0;
    op_a_i     = '0;
    op_b_i     = '0;
    exp_result = '0;
    op_active  = 1'b0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    random_unsigned();
    signed_modes();
    divide_by_zero();
    fixed_latency();
    held_result();
    enable_pause();
    reset_with_valid();
    // Let the checks on the last acceptance complete
    repeat (4) @(posedge clk_i);
    $display("summary: %0d operations, %0d errors", op_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired before all tests finished");
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/div_unit.sv
/*
 * Iterative integer divider
 * Signed or unsigned 32-bit DIV and REM, one quotient bit per cycle
 */

`default_nettype none

module div_unit import div_types_pkg::*, div_ctrl_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      en_i,
  input  div_op_e   op_i,
  input  div_mode_t mode_i,
  input  div_word_t op_a_i,
  input  div_word_t op_b_i,
  input  logic      ready_i,
  output div_word_t result_o,
  output logic      valid_o
);

  div_state_e state;
  logic       cnt_load;
  logic       cnt_dec;
  div_cnt_t   cnt;
  logic       cnt_last;
  div_word_t  sum;
  logic       ge;
  logic       b_zero;
  div_rem_t   rem;
  div_word_t  denom;

  div_ctrl_fsm i_div_ctrl_fsm (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .en_i       (en_i),
    .ready_i    (ready_i),
    .b_zero_i   (b_zero),
    .cnt_last_i (cnt_last),
    .state_o    (state),
    .cnt_load_o (cnt_load),
    .cnt_dec_o  (cnt_dec),
    .valid_o    (valid_o)
  );

  div_bit_counter i_div_bit_counter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   (en_i),
    .load_i (cnt_load),
    .dec_i  (cnt_dec),
    .cnt_o  (cnt),
    .last_o (cnt_last)
  );

  div_adder i_div_adder (
    .state_i  (state),
    .op_a_i   (op_a_i),
    .op_b_i   (op_b_i),
    .rem_i    (rem),
    .denom_i  (denom),
    .sum_o    (sum),
    .ge_o     (ge),
    .b_zero_o (b_zero)
  );

  div_regs i_div_regs (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .en_i     (en_i),
    .state_i  (state),
    .op_i     (op_i),
    .mode_i   (mode_i),
    .op_a_i   (op_a_i),
    .op_b_i   (op_b_i),
    .cnt_i    (cnt),
    .sum_i    (sum),
    .ge_i     (ge),
    .numer_o  (),
    .denom_o  (denom),
    .rem_o    (rem),
    .result_o (result_o)
  );

endmodule

`default_nettype wire

// File: hw/div_regs.sv
/*
 * Divider data path registers
 * Numerator, denominator, quotient and remainder with next-value selection
 */

`default_nettype none

`include "div_consts.svh"

module div_regs import div_types_pkg::*, div_ctrl_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       en_i,
  input  div_state_e state_i,
  input  div_op_e    op_i,
  input  div_mode_t  mode_i,
  input  div_word_t  op_a_i,
  input  div_word_t  op_b_i,
  input  div_cnt_t   cnt_i,
  input  div_word_t  sum_i,
  input  logic       ge_i,
  output div_word_t  numer_o,
  output div_word_t  denom_o,
  output div_rem_t   rem_o,
  output div_word_t  result_o
);

  div_word_t numer_q, numer_d;
  div_word_t denom_q, denom_d;
  div_word_t quot_q, quot_d;
  div_rem_t  rem_q, rem_d;

  div_word_t next_rem;
  div_word_t next_quot;
  div_word_t one_shift;
  div_cnt_t  shift_idx;
  logic      sign_a;
  logic      sign_b;
  logic      quot_neg;

  assign sign_a = mode_i[0] & op_a_i[`DIV_WIDTH-1];
  assign sign_b = mode_i[1] & op_b_i[`DIV_WIDTH-1];
  // A zero divisor never reaches the sign phase, so B is nonzero here
  assign quot_neg = sign_a ^ sign_b;

  // Compare step result
  assign one_shift = {{(`DIV_WIDTH-1){1'b0}}, 1'b1} << cnt_i;
  assign next_rem  = ge_i ? sum_i : rem_q[`DIV_WIDTH-1:0];
  assign next_quot = ge_i ? (quot_q | one_shift) : quot_q;
  // Numerator bit that joins the remainder for the next step
  assign shift_idx = cnt_i - div_cnt_t'(1);

  always_comb begin
    numer_d = numer_q;
    denom_d = denom_q;
    quot_d  = quot_q;
    rem_d   = rem_q;

    unique case (state_i)
      DIV_IDLE: begin
        // Divide-by-zero results, replaced later for a nonzero B
        if (op_i == DIV_OP_DIV) begin
          rem_d = {1'b0, {`DIV_WIDTH{1'b1}}};
        end else begin
          rem_d = {1'b0, op_a_i};
        end
      end
      DIV_ABS_A: begin
        quot_d  = '0;
        numer_d = sign_a ? sum_i : op_a_i;
      end
      DIV_ABS_B: begin
        rem_d   = {{`DIV_WIDTH{1'b0}}, numer_q[`DIV_WIDTH-1]};
        denom_d = sign_b ? sum_i : op_b_i;
      end
      DIV_COMP: begin
        rem_d  = {next_rem, numer_q[shift_idx]};
        quot_d = next_quot;
      end
      DIV_LAST: begin
        // Keep only the value the operation returns
        if (op_i == DIV_OP_DIV) begin
          rem_d = {1'b0, next_quot};
        end else begin
          rem_d = {1'b0, next_rem};
        end
      end
      DIV_SIGN: begin
        if (op_i == DIV_OP_DIV) begin
          rem_d = quot_neg ? {1'b0, sum_i} : rem_q;
        end else begin
          // Remainder takes the sign of the dividend
          rem_d = sign_a ? {1'b0, sum_i} : rem_q;
        end
      end
      default: begin
        rem_d = rem_q;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rem_q <= '0;
    end else if (en_i) begin
      rem_q <= rem_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      numer_q <= numer_d;
      denom_q <= denom_d;
      quot_q  <= quot_d;
    end
  end

  assign numer_o  = numer_q;
  assign denom_o  = denom_q;
  assign rem_o    = rem_q;
  assign result_o = rem_q[`DIV_WIDTH-1:0];

endmodule

`default_nettype wire

// File: hw/div_adder.sv
/*
 * Divider adder
 * One subtractor for absolute values, remainder compare and sign change
 */

`default_nettype none

`include "div_consts.svh"

module div_adder import div_types_pkg::*, div_ctrl_pkg::*; (
  input  div_state_e state_i,
  input  div_word_t  op_a_i,
  input  div_word_t  op_b_i,
  input  div_rem_t   rem_i,
  input  div_word_t  denom_i,
  output div_word_t  sum_o,
  output logic       ge_o,
  output logic       b_zero_o
);

  div_word_t             add_a;
  div_word_t             add_b;
  logic [`DIV_WIDTH:0]   add_res;

  // Minuend and subtrahend per phase
  always_comb begin
    add_a = '0;
    add_b = op_b_i;

    unique case (state_i)
      DIV_ABS_A: begin
        add_b = op_a_i;
      end
      DIV_COMP, DIV_LAST: begin
        add_a = rem_i[`DIV_WIDTH-1:0];
        add_b = denom_i;
      end
      DIV_SIGN: begin
        add_b = rem_i[`DIV_WIDTH-1:0];
      end
      default: begin
        add_b = op_b_i;
      end
    endcase
  end

  // a - b as a + ~b + 1, carry out means no borrow
  assign add_res = {1'b0, add_a} + {1'b0, ~add_b} + {{`DIV_WIDTH{1'b0}}, 1'b1};
  assign sum_o   = add_res[`DIV_WIDTH-1:0];

  // 0 - B only completes without borrow when B is zero
  assign b_zero_o = (state_i == DIV_IDLE) && add_res[`DIV_WIDTH];

  always_comb begin
    if (rem_i[`DIV_WIDTH]) begin
      ge_o = 1'b1;
    end else if (rem_i[`DIV_WIDTH-1] == denom_i[`DIV_WIDTH-1]) begin
      ge_o = ~add_res[`DIV_WIDTH-1];
    end else begin
      // Top bits differ, the one with the top bit set is larger
      ge_o = rem_i[`DIV_WIDTH-1];
    end
  end

endmodule

`default_nettype wire

// File: hw/div_bit_counter.sv
/*
 * Quotient bit counter
 * Counts down the quotient bit index and flags the last compare step
 */

`default_nettype none

`include "div_consts.svh"

module div_bit_counter import div_types_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     en_i,
  input  logic     load_i,
  input  logic     dec_i,
  output div_cnt_t cnt_o,
  output logic     last_o
);

  div_cnt_t cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (en_i) begin
      if (load_i) begin
        cnt_q <= div_cnt_t'(`DIV_CNT_START);
      end else if (dec_i) begin
        cnt_q <= cnt_q - div_cnt_t'(1);
      end
    end
  end

  assign cnt_o  = cnt_q;
  // Bit 0 is decided in the last phase, so the loop ends at one
  assign last_o = (cnt_q == div_cnt_t'(1));

endmodule

`default_nettype wire

// File: hw/div_ctrl_fsm.sv
/*
 * Divider controller
 * Steps through the division phases and holds the result until accepted
 */

`default_nettype none

module div_ctrl_fsm import div_ctrl_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       en_i,
  input  logic       ready_i,
  input  logic       b_zero_i,
  input  logic       cnt_last_i,
  output div_state_e state_o,
  output logic       cnt_load_o,
  output logic       cnt_dec_o,
  output logic       valid_o
);

  div_state_e state_q;
  div_state_e state_d;

  always_comb begin
    state_d = state_q;

    unique case (state_q)
      DIV_IDLE: begin
        // Division by zero skips straight to the result
        state_d = b_zero_i ? DIV_FINISH : DIV_ABS_A;
      end
      DIV_ABS_A: begin
        state_d = DIV_ABS_B;
      end
      DIV_ABS_B: begin
        state_d = DIV_COMP;
      end
      DIV_COMP: begin
        if (cnt_last_i) begin
          state_d = DIV_LAST;
        end
      end
      DIV_LAST: begin
        state_d = DIV_SIGN;
      end
      DIV_SIGN: begin
        state_d = DIV_FINISH;
      end
      DIV_FINISH: begin
        // Wait here until the caller takes the result
        if (ready_i) begin
          state_d = DIV_IDLE;
        end
      end
      default: begin
        state_d = DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DIV_IDLE;
    end else if (en_i) begin
      state_q <= state_d;
    end
  end

  // Counter starts over in every phase before the compare loop
  assign cnt_load_o = (state_q == DIV_IDLE) || (state_q == DIV_ABS_A) ||
                      (state_q == DIV_ABS_B);
  assign cnt_dec_o  = (state_q == DIV_COMP);
  assign valid_o    = (state_q == DIV_FINISH);
  assign state_o    = state_q;

endmodule

`default_nettype wire

// File: hw/div_ctrl_pkg.sv
/*
 * Divider control types
 * Operation select and the phases of the divider state machine
 */

`default_nettype none

package div_ctrl_pkg;

  typedef enum logic {
    DIV_OP_DIV,
    DIV_OP_REM
  } div_op_e;

  typedef enum logic [2:0] {
    DIV_IDLE,
    DIV_ABS_A,
    DIV_ABS_B,
    DIV_COMP,
    DIV_LAST,
    DIV_SIGN,
    DIV_FINISH
  } div_state_e;

endpackage

`default_nettype wire

// File: hw/div_types_pkg.sv
/*
 * Divider data types
 * Vector types for operands, the partial remainder, the bit index and the mode
 */

`default_nettype none

`include "div_consts.svh"

package div_types_pkg;

  // Operand, quotient or result word
  typedef logic [`DIV_WIDTH-1:0] div_word_t;

  // Partial remainder with one spare top bit
  typedef logic [`DIV_WIDTH:0] div_rem_t;

  // Index of the quotient bit being decided
  typedef logic [`DIV_CNT_W-1:0] div_cnt_t;

  // Bit 0 marks A as signed, bit 1 marks B as signed
  typedef logic [1:0] div_mode_t;

endpackage

`default_nettype wire

// File: hw/div_consts.svh
/*
 * Divider constants
 * Operand width and quotient bit index range of the iterative divider
 */

`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// Operand and result width
`define DIV_WIDTH 32

// Width of the quotient bit index
`define DIV_CNT_W 5

// Index of the first quotient bit decided in the compare phase
`define DIV_CNT_START 31

`endif
